//--- src/qdrc_pkg.sv
package qdrc_pkg;

  // sram geometry.
  localparam int DATA_WIDTH = 18;  // bits per half-cycle.
  localparam int BW_WIDTH   = 2;
  localparam int ADDR_WIDTH = 21;

  // calibration limits.
  localparam int TAP_MAX         = 31;
  localparam int DLL_LOCK_CYCLES = 64;
  localparam int RD_LAT_MAX      = 8;

  // counter widths derived from the limits.
  localparam int TAP_WIDTH  = $clog2(TAP_MAX + 1);
  localparam int LAT_WIDTH  = $clog2(RD_LAT_MAX + 3);
  localparam int LOCK_WIDTH = $clog2(DLL_LOCK_CYCLES + 1);

  // calibration address and burst words.
  localparam logic [ADDR_WIDTH-1:0] CAL_ADDR = 21'h1f_fff0;
  localparam logic [DATA_WIDTH-1:0] PAT_A    = 18'h2_a5c3;
  localparam logic [DATA_WIDTH-1:0] PAT_B    = 18'h1_5a3c;

  // one cycle of pin outputs toward the sram.
  typedef struct packed {
    logic                  w_n;
    logic                  r_n;
    logic [ADDR_WIDTH-1:0] sa;
    logic [DATA_WIDTH-1:0] d_rise;
    logic [DATA_WIDTH-1:0] d_fall;
    logic [BW_WIDTH-1:0]   bw_n_rise;
    logic [BW_WIDTH-1:0]   bw_n_fall;
  } qdr_cmd_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] rise;
    logic [DATA_WIDTH-1:0] fall;
  } qdr_q_t;

  // per-bit delay line control.
  typedef struct packed {
    logic [DATA_WIDTH-1:0] inc_dec_n;
    logic [DATA_WIDTH-1:0] en;
    logic [DATA_WIDTH-1:0] rst;
  } dly_ctrl_t;

  typedef struct packed {
    logic                    wr_strb;
    logic                    rd_strb;
    logic [ADDR_WIDTH-1:0]   addr;
    logic [2*DATA_WIDTH-1:0] wr_data;  // fall half in the upper bits.
    logic [2*BW_WIDTH-1:0]   wr_ben;   // active high.
  } phy_req_t;

  // no write, no read, all lanes masked.
  localparam qdr_cmd_t QDR_CMD_IDLE = '{w_n: 1'b1, r_n: 1'b1, sa: '0, d_rise: '0,
                                        d_fall: '0, bw_n_rise: '1, bw_n_fall: '1};

endpackage

//--- src/qdrc_phy_sm.sv
module qdrc_phy_sm (
  input  logic clk0,
  input  logic rst_n,
  input  logic bit_align_done,
  input  logic bit_align_fail,
  input  logic burst_align_done,
  input  logic burst_align_fail,
  output logic qdr_dll_off_n,
  output logic bit_align_start,
  output logic burst_align_start,
  output logic phy_rdy,
  output logic cal_fail
);
  import qdrc_pkg::*;

  typedef enum logic [2:0] {
    S_LOCK,
    S_BIT,
    S_BURST,
    S_READY,
    S_FAILED
  } state_t;

  state_t                state;
  logic [LOCK_WIDTH-1:0] lock_cnt;  // cycles since dll enable.

  always_ff @(posedge clk0 or negedge rst_n) begin
    if (!rst_n) begin
      state             <= S_LOCK;
      lock_cnt          <= '0;
      qdr_dll_off_n     <= 1'b0;
      bit_align_start   <= 1'b0;
      burst_align_start <= 1'b0;
    end else begin
      qdr_dll_off_n     <= 1'b1;  // dll on from the first cycle.
      bit_align_start   <= 1'b0;
      burst_align_start <= 1'b0;
      case (state)
        S_LOCK: begin
          if (lock_cnt == LOCK_WIDTH'(DLL_LOCK_CYCLES)) begin
            bit_align_start <= 1'b1;
            state           <= S_BIT;
          end else begin
            lock_cnt <= lock_cnt + 1'b1;
          end
        end
        S_BIT: begin
          if (bit_align_fail) begin
            state <= S_FAILED;
          end else if (bit_align_done) begin
            burst_align_start <= 1'b1;
            state             <= S_BURST;
          end
        end
        S_BURST: begin
          if (burst_align_fail) begin
            state <= S_FAILED;
          end else if (burst_align_done) begin
            state <= S_READY;
          end
        end
        default: state <= state;  // ready and failed hold until reset.
      endcase
    end
  end

  assign phy_rdy  = (state == S_READY);
  assign cal_fail = (state == S_FAILED);

endmodule

//--- src/qdrc_phy_bit_align.sv
module qdrc_phy_bit_align (
  input  logic                clk0,
  input  logic                rst_n,
  input  logic                bit_align_start,
  input  qdrc_pkg::qdr_q_t    qdr_q,
  output qdrc_pkg::qdr_cmd_t  cmd,
  output qdrc_pkg::dly_ctrl_t dly,
  output qdrc_pkg::qdr_q_t    q_cal,
  output logic                bit_align_done,
  output logic                bit_align_fail
);
  import qdrc_pkg::*;

  typedef enum logic [3:0] {
    S_IDLE,
    S_RST,
    S_WRITE,
    S_READ,
    S_WAIT,
    S_CHECK,
    S_STEP,
    S_DONE,
    S_FAIL
  } state_t;

  state_t                state;
  logic [LAT_WIDTH-1:0]  wait_cnt;
  logic [DATA_WIDTH-1:0] bit_ok;     // bits seen as rise 1, fall 0 this probe.
  logic [DATA_WIDTH-1:0] bit_bad;
  logic [DATA_WIDTH-1:0] step_mask;  // bits to increment.
  logic [DATA_WIDTH-1:0] tap_at_max;
  logic [TAP_WIDTH-1:0]  tap_cnt [DATA_WIDTH];

  // taps act inside the sram here, so one register stage.
  always_ff @(posedge clk0) begin
    q_cal <= qdr_q;
  end

  always_comb begin
    bit_bad = ~bit_ok;
    for (int i = 0; i < DATA_WIDTH; i++) begin
      tap_at_max[i] = (tap_cnt[i] == TAP_WIDTH'(TAP_MAX));
    end
  end

  always_ff @(posedge clk0 or negedge rst_n) begin
    if (!rst_n) begin
      state     <= S_IDLE;
      wait_cnt  <= '0;
      bit_ok    <= '0;
      step_mask <= '0;
      for (int i = 0; i < DATA_WIDTH; i++) begin
        tap_cnt[i] <= '0;
      end
    end else begin
      case (state)
        S_IDLE: if (bit_align_start) state <= S_RST;
        S_RST: begin
          for (int i = 0; i < DATA_WIDTH; i++) begin
            tap_cnt[i] <= '0;
          end
          state <= S_WRITE;
        end
        S_WRITE: state <= S_READ;
        S_READ: begin
          bit_ok   <= '0;
          wait_cnt <= '0;
          state    <= S_WAIT;
        end
        S_WAIT: begin
          // latency is unknown yet, so collect over the whole window.
          bit_ok <= bit_ok | (q_cal.rise & ~q_cal.fall);
          if (wait_cnt == LAT_WIDTH'(RD_LAT_MAX + 1)) state <= S_CHECK;
          else wait_cnt <= wait_cnt + 1'b1;
        end
        S_CHECK: begin
          step_mask <= bit_bad;
          if (bit_bad == '0) state <= S_DONE;
          else if ((bit_bad & tap_at_max) != '0) state <= S_FAIL;  // out of taps.
          else state <= S_STEP;
        end
        S_STEP: begin
          for (int i = 0; i < DATA_WIDTH; i++) begin
            if (step_mask[i]) tap_cnt[i] <= tap_cnt[i] + 1'b1;
          end
          state <= S_WRITE;  // next probe.
        end
        default: state <= state;
      endcase
    end
  end

  // rise all ones, fall all zeros at the calibration address.
  always_comb begin
    cmd        = QDR_CMD_IDLE;
    cmd.sa     = CAL_ADDR;
    cmd.d_rise = '1;
    cmd.d_fall = '0;
    if (state == S_WRITE) begin
      cmd.w_n       = 1'b0;
      cmd.bw_n_rise = '0;
      cmd.bw_n_fall = '0;
    end
    if (state == S_READ) cmd.r_n = 1'b0;
  end

  assign dly = '{inc_dec_n: '1,
                 en:        (state == S_STEP) ? step_mask : '0,
                 rst:       {DATA_WIDTH{state == S_RST}}};

  assign bit_align_done = (state == S_DONE);
  assign bit_align_fail = (state == S_FAIL);

endmodule

//--- src/qdrc_phy_burst_align.sv
module qdrc_phy_burst_align (
  input  logic               clk0,
  input  logic               rst_n,
  input  logic               burst_align_start,
  input  qdrc_pkg::qdr_q_t   q_cal,
  input  logic               user_rd_strb,
  output qdrc_pkg::qdr_cmd_t cmd,
  output qdrc_pkg::qdr_q_t   rd_q,
  output logic               rd_valid,
  output logic               burst_align_done,
  output logic               burst_align_fail
);
  import qdrc_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_WRITE,
    S_READ,
    S_WAIT,
    S_DONE,
    S_FAIL
  } state_t;

  state_t               state;
  logic [LAT_WIDTH-1:0] lat_cnt;  // cycles since the read left the pins.
  logic [LAT_WIDTH-1:0] rd_dly;   // user strobe to rd_valid.
  logic                 shift;    // word split across two cycles.
  logic [RD_LAT_MAX:0]  strb_sr;
  qdr_q_t               q_prev;
  logic                 hit_aligned;
  logic                 hit_shifted;

  always_ff @(posedge clk0) begin
    q_prev <= q_cal;
  end

  assign hit_aligned = (q_cal.rise == PAT_A) && (q_cal.fall == PAT_B);
  assign hit_shifted = (q_prev.fall == PAT_A) && (q_cal.rise == PAT_B);

  always_ff @(posedge clk0 or negedge rst_n) begin
    if (!rst_n) begin
      state   <= S_IDLE;
      lat_cnt <= '0;
      rd_dly  <= LAT_WIDTH'(1);
      shift   <= 1'b0;
      strb_sr <= '0;
    end else begin
      strb_sr <= {strb_sr[RD_LAT_MAX-1:0], user_rd_strb};
      case (state)
        S_IDLE:  if (burst_align_start) state <= S_WRITE;
        S_WRITE: state <= S_READ;
        S_READ: begin
          lat_cnt <= LAT_WIDTH'(1);
          state   <= S_WAIT;
        end
        S_WAIT: begin
          if (hit_aligned) begin
            // output stage adds one cycle.
            rd_dly <= lat_cnt + 1'b1;
            shift  <= 1'b0;
            state  <= S_DONE;
          end else if (hit_shifted) begin
            rd_dly <= lat_cnt;  // pairing is ready at once.
            shift  <= 1'b1;
            state  <= S_DONE;
          end else if (lat_cnt == LAT_WIDTH'(RD_LAT_MAX)) begin
            state <= S_FAIL;
          end else begin
            lat_cnt <= lat_cnt + 1'b1;
          end
        end
        default: state <= state;
      endcase
    end
  end

  // shifted words pair the previous fall with the current rise.
  always_comb begin
    if (shift) begin
      rd_q.rise = q_prev.fall;
      rd_q.fall = q_cal.rise;
    end else begin
      rd_q = q_prev;
    end
  end

  assign rd_valid = (state == S_DONE) && strb_sr[rd_dly - 1'b1];

  always_comb begin
    cmd        = QDR_CMD_IDLE;
    cmd.sa     = CAL_ADDR;
    cmd.d_rise = PAT_A;
    cmd.d_fall = PAT_B;
    if (state == S_WRITE) begin
      cmd.w_n       = 1'b0;
      cmd.bw_n_rise = '0;
      cmd.bw_n_fall = '0;
    end
    if (state == S_READ) cmd.r_n = 1'b0;
  end

  assign burst_align_done = (state == S_DONE);
  assign burst_align_fail = (state == S_FAIL);

endmodule

//--- src/qdrc_phy.sv
module qdrc_phy (
  input  logic                                clk0,
  input  logic                                rst_n,
  input  qdrc_pkg::phy_req_t                  phy_req,
  output logic [2*qdrc_pkg::DATA_WIDTH-1:0]   phy_rd_data,
  output logic                                phy_rd_valid,
  output logic                                phy_rdy,
  output logic                                cal_fail,
  output qdrc_pkg::qdr_cmd_t                  qdr_out,
  input  qdrc_pkg::qdr_q_t                    qdr_q,
  output logic                                qdr_dll_off_n,
  output qdrc_pkg::dly_ctrl_t                 dly
);
  import qdrc_pkg::*;

  logic     bit_align_start;
  logic     bit_align_done;
  logic     bit_align_fail;
  logic     burst_align_start;
  logic     burst_align_done;
  logic     burst_align_fail;
  logic     user_sel;      // user path owns the pins.
  logic     user_rd_strb;
  qdr_cmd_t bit_cmd;
  qdr_cmd_t burst_cmd;
  qdr_cmd_t user_cmd;
  qdr_q_t   q_cal;
  qdr_q_t   rd_q;

  qdrc_phy_sm u_sm (
    .clk0              (clk0),
    .rst_n             (rst_n),
    .bit_align_done    (bit_align_done),
    .bit_align_fail    (bit_align_fail),
    .burst_align_done  (burst_align_done),
    .burst_align_fail  (burst_align_fail),
    .qdr_dll_off_n     (qdr_dll_off_n),
    .bit_align_start   (bit_align_start),
    .burst_align_start (burst_align_start),
    .phy_rdy           (phy_rdy),
    .cal_fail          (cal_fail)
  );

  qdrc_phy_bit_align u_bit_align (
    .clk0            (clk0),
    .rst_n           (rst_n),
    .bit_align_start (bit_align_start),
    .qdr_q           (qdr_q),
    .cmd             (bit_cmd),
    .dly             (dly),
    .q_cal           (q_cal),
    .bit_align_done  (bit_align_done),
    .bit_align_fail  (bit_align_fail)
  );

  qdrc_phy_burst_align u_burst_align (
    .clk0              (clk0),
    .rst_n             (rst_n),
    .burst_align_start (burst_align_start),
    .q_cal             (q_cal),
    .user_rd_strb      (user_rd_strb),
    .cmd               (burst_cmd),
    .rd_q              (rd_q),
    .rd_valid          (phy_rd_valid),
    .burst_align_done  (burst_align_done),
    .burst_align_fail  (burst_align_fail)
  );

  assign user_sel     = bit_align_done & burst_align_done & ~cal_fail;
  assign user_rd_strb = user_sel & phy_req.rd_strb;  // only reads that reach the pins.

  // strobes and byte enables are active low on the pins.
  assign user_cmd = '{w_n:       ~phy_req.wr_strb,
                      r_n:       ~phy_req.rd_strb,
                      sa:        phy_req.addr,
                      d_rise:    phy_req.wr_data[DATA_WIDTH-1:0],
                      d_fall:    phy_req.wr_data[2*DATA_WIDTH-1:DATA_WIDTH],
                      bw_n_rise: ~phy_req.wr_ben[BW_WIDTH-1:0],
                      bw_n_fall: ~phy_req.wr_ben[2*BW_WIDTH-1:BW_WIDTH]};

  // pin owner follows the done levels.
  always_comb begin
    if (cal_fail) qdr_out = QDR_CMD_IDLE;
    else if (!bit_align_done) qdr_out = bit_cmd;
    else if (!burst_align_done) qdr_out = burst_cmd;
    else qdr_out = user_cmd;
  end

  assign phy_rd_data = {rd_q.fall, rd_q.rise};

endmodule

//--- verification/qdrc_sram_model.sv
module qdrc_sram_model #(
  parameter int RD_LAT = 3
) (
  input  logic                                 clk0,
  input  qdrc_pkg::qdr_cmd_t                   cmd,
  input  qdrc_pkg::dly_ctrl_t                  dly,
  input  logic [qdrc_pkg::DATA_WIDTH-1:0][7:0] skew,
  input  logic                                 shift,
  output qdrc_pkg::qdr_q_t                     q
);
  timeunit 1ns;
  timeprecision 100ps;
  import qdrc_pkg::*;

  localparam int WORD_W = 2 * DATA_WIDTH;
  localparam int LANE_W = DATA_WIDTH / BW_WIDTH;

  logic [WORD_W-1:0]     mem [64];         // low 6 address bits only.
  logic [WORD_W-1:0]     pipe [RD_LAT+1];  // zero where no read was issued.
  logic [7:0]            taps [DATA_WIDTH];
  logic [WORD_W-1:0]     wr_word;
  logic [2*BW_WIDTH-1:0] wr_bw_n;
  qdr_q_t                word_q;

  initial begin
    for (int a = 0; a < 64; a++) begin
      mem[a] = {6{6'(a)}} ^ 36'h9_6c3a_5f21;
    end
    for (int k = 0; k <= RD_LAT; k++) begin
      pipe[k] = '0;
    end
    for (int i = 0; i < DATA_WIDTH; i++) begin
      taps[i] = '0;
    end
  end

  assign wr_word = {cmd.d_fall, cmd.d_rise};
  assign wr_bw_n = {cmd.bw_n_fall, cmd.bw_n_rise};

  always @(posedge clk0) begin
    if (!cmd.w_n) begin
      for (int l = 0; l < 2 * BW_WIDTH; l++) begin
        if (!wr_bw_n[l]) mem[cmd.sa[5:0]][l*LANE_W +: LANE_W] <= wr_word[l*LANE_W +: LANE_W];
      end
    end
    pipe[0] <= cmd.r_n ? '0 : mem[cmd.sa[5:0]];
    for (int k = 1; k <= RD_LAT; k++) begin
      pipe[k] <= pipe[k-1];
    end
    for (int i = 0; i < DATA_WIDTH; i++) begin
      if (dly.rst[i]) taps[i] <= '0;
      else if (dly.en[i] && dly.inc_dec_n[i]) taps[i] <= taps[i] + 1'b1;
    end
  end

  always_comb begin
    if (shift) begin
      // word lands half a cycle late.
      word_q.rise = pipe[RD_LAT][WORD_W-1:DATA_WIDTH];
      word_q.fall = pipe[RD_LAT-1][DATA_WIDTH-1:0];
    end else begin
      word_q.rise = pipe[RD_LAT-1][DATA_WIDTH-1:0];
      word_q.fall = pipe[RD_LAT-1][WORD_W-1:DATA_WIDTH];
    end
    q = word_q;
    for (int i = 0; i < DATA_WIDTH; i++) begin
      if (taps[i] < skew[i]) begin  // bit still sampled on the wrong edge.
        q.rise[i] = word_q.fall[i];
        q.fall[i] = word_q.rise[i];
      end
    end
  end

endmodule

//--- verification/qdrc_phy_sva.sv
module qdrc_phy_sva (
  input logic                clk0,
  input logic                rst_n,
  input logic                bit_align_start,
  input logic                phy_rd_valid,
  input logic                phy_rdy,
  input logic                cal_fail,
  input logic                qdr_dll_off_n,
  input qdrc_pkg::qdr_cmd_t  qdr_out,
  input qdrc_pkg::dly_ctrl_t dly
);
  timeunit 1ns;
  timeprecision 100ps;
  import qdrc_pkg::*;

  int   fail_cnt = 0;
  logic cal_started;  // set by the first calibration start.

  always @(posedge clk0 or negedge rst_n) begin
    if (!rst_n) cal_started <= 1'b0;
    else if (bit_align_start) cal_started <= 1'b1;
  end

  a_idle_before_cal: assert property (@(posedge clk0) !cal_started |->
      !phy_rdy && !cal_fail && !phy_rd_valid && (dly.en == '0) && qdr_out.w_n && qdr_out.r_n)
    else begin
      $error("outputs not idle before calibration start");
      fail_cnt++;
    end

  // dll enabled from the first cycle out of reset.
  a_dll_on: assert property (@(posedge clk0) qdr_dll_off_n == (rst_n && $past(rst_n)))
    else begin
      $error("dll enable not high from the first cycle after reset");
      fail_cnt++;
    end

  a_lock_wait: assert property (@(posedge clk0) disable iff (!rst_n)
      $rose(qdr_dll_off_n) |-> ##DLL_LOCK_CYCLES bit_align_start)
    else begin
      $error("bit alignment did not start after the dll lock wait");
      fail_cnt++;
    end

  a_rdy_fail_excl: assert property (@(posedge clk0) !(phy_rdy && cal_fail))
    else begin
      $error("phy_rdy and cal_fail high together");
      fail_cnt++;
    end

  a_no_tap_after_rdy: assert property (@(posedge clk0) phy_rdy |-> (dly.en == '0))
    else begin
      $error("delay tap step after phy_rdy");
      fail_cnt++;
    end

  a_pins_idle_on_fail: assert property (@(posedge clk0) cal_fail |->
      qdr_out.w_n && qdr_out.r_n && !phy_rd_valid)
    else begin
      $error("user traffic reached the pins after cal_fail");
      fail_cnt++;
    end

endmodule

bind qdrc_phy qdrc_phy_sva u_sva (.*);

//--- verification/qdrc_phy_tb.sv
module qdrc_phy_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import qdrc_pkg::*;

  localparam int SEED_INIT       = 32'hccd7_d3d1;
  localparam int MODEL_LAT       = 3;
  localparam int SKEW_SPAN       = 21;  // skews 0 to 20.
  localparam int FAIL_SKEW       = 40;
  localparam int CLK_HALF        = 4;
  localparam int RAND_OPS        = 150;
  localparam int LANE_W          = DATA_WIDTH / BW_WIDTH;
  localparam int SCEN_CYCLES     = DLL_LOCK_CYCLES + DATA_WIDTH * (TAP_MAX + 1) * (RD_LAT_MAX + 4)
                                   + 200;
  localparam int WATCHDOG_CYCLES = 3 * SCEN_CYCLES;

  logic                       clk0 = 1'b0;
  logic                       rst_n;
  phy_req_t                   phy_req;
  logic [2*DATA_WIDTH-1:0]    phy_rd_data;
  logic                       phy_rd_valid;
  logic                       phy_rdy;
  logic                       cal_fail;
  logic                       qdr_dll_off_n;
  qdr_cmd_t                   qdr_out;
  qdr_q_t                     qdr_q;
  dly_ctrl_t                  dly;
  logic                       shift_mode;
  logic                       model_shift;
  logic [DATA_WIDTH-1:0][7:0] skew;
  int                         inc_cnt [DATA_WIDTH];
  logic [2*DATA_WIDTH-1:0]    ref_mem [32];
  logic [2*DATA_WIDTH-1:0]    exp_q [$];
  logic [2*DATA_WIDTH-1:0]    exp_word;
  integer                     seed;
  int                         errors;
  int                         reads_checked;

  always #CLK_HALF clk0 = ~clk0;

  qdrc_phy dut (
    .clk0          (clk0),
    .rst_n         (rst_n),
    .phy_req       (phy_req),
    .phy_rd_data   (phy_rd_data),
    .phy_rd_valid  (phy_rd_valid),
    .phy_rdy       (phy_rdy),
    .cal_fail      (cal_fail),
    .qdr_out       (qdr_out),
    .qdr_q         (qdr_q),
    .qdr_dll_off_n (qdr_dll_off_n),
    .dly           (dly)
  );

  // the slip sets in once the per-bit taps have settled.
  assign model_shift = shift_mode && dut.bit_align_done;

  qdrc_sram_model #(.RD_LAT(MODEL_LAT)) u_sram (
    .clk0  (clk0),
    .cmd   (qdr_out),
    .dly   (dly),
    .skew  (skew),
    .shift (model_shift),
    .q     (qdr_q)
  );

  always @(posedge clk0) begin
    for (int i = 0; i < DATA_WIDTH; i++) begin
      if (dly.rst[i]) inc_cnt[i] <= 0;
      else if (dly.en[i] && dly.inc_dec_n[i]) inc_cnt[i] <= inc_cnt[i] + 1;
    end
  end

  always @(posedge clk0) begin
    if (phy_rd_valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("ERR %0t: read data returned with no read outstanding", $time);
      end else begin
        exp_word = exp_q.pop_front();
        reads_checked++;
        assert (phy_rd_data == exp_word) else begin
          errors++;
          $display("ERR %0t: read data %h, expected %h", $time, phy_rd_data, exp_word);
        end
      end
    end
  end

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (5) @(negedge clk0);
    rst_n = 1'b1;
  endtask

  task automatic seed_skews(input int bad_bit);
    for (int i = 0; i < DATA_WIDTH; i++) begin
      skew[i] = 8'($unsigned($random(seed)) % SKEW_SPAN);
    end
    if (bad_bit >= 0) skew[bad_bit] = 8'(FAIL_SKEW);  // beyond the tap range.
  endtask

  task automatic write_word(input logic [4:0] idx, input logic [2*BW_WIDTH-1:0] ben);
    logic [2*DATA_WIDTH-1:0] data;
    data = (2*DATA_WIDTH)'({$random(seed), $random(seed)});
    phy_req         = '0;
    phy_req.wr_strb = 1'b1;
    phy_req.addr    = {15'($random(seed)), 1'b0, idx};
    phy_req.wr_data = data;
    phy_req.wr_ben  = ben;
    for (int l = 0; l < 2 * BW_WIDTH; l++) begin
      if (ben[l]) ref_mem[idx][l*LANE_W +: LANE_W] = data[l*LANE_W +: LANE_W];
    end
    @(negedge clk0);
  endtask

  task automatic read_word(input logic [4:0] idx);
    phy_req         = '0;
    phy_req.rd_strb = 1'b1;
    phy_req.addr    = {15'($random(seed)), 1'b0, idx};
    exp_q.push_back(ref_mem[idx]);
    @(negedge clk0);
  endtask

  task automatic run_traffic();
    int op;
    for (int a = 0; a < 32; a++) write_word(5'(a), '1);
    for (int n = 0; n < RAND_OPS; n++) begin
      op = $unsigned($random(seed)) % 4;
      if (op == 0) write_word(5'($random(seed)), '1);
      else if (op == 1) write_word(5'($random(seed)), 4'($random(seed)));  // partial ben.
      else read_word(5'($random(seed)));
    end
    phy_req = '0;
    while (exp_q.size() != 0) @(negedge clk0);
  endtask

  task automatic run_scenario(input logic slip, input int bad_bit);
    shift_mode = slip;
    seed_skews(bad_bit);
    apply_reset();
    while (!phy_rdy && !cal_fail) @(negedge clk0);
    if (bad_bit < 0) begin
      assert (phy_rdy) else begin
        errors++;
        $display("ERR %0t: calibration failed with skews in range", $time);
      end
      for (int i = 0; i < DATA_WIDTH; i++) begin
        assert (inc_cnt[i] == int'(skew[i])) else begin
          errors++;
          $display("ERR %0t: bit %0d got %0d taps, skew %0d", $time, i, inc_cnt[i], skew[i]);
        end
      end
      run_traffic();
    end else begin
      assert (cal_fail && !phy_rdy) else begin
        errors++;
        $display("ERR %0t: out-of-range skew on bit %0d not flagged", $time, bad_bit);
      end
      for (int n = 0; n < 40; n++) begin
        phy_req         = '0;
        phy_req.wr_strb = n[0];
        phy_req.rd_strb = 1'b1;
        phy_req.addr    = ADDR_WIDTH'($random(seed));
        phy_req.wr_ben  = '1;
        @(negedge clk0);
      end
      phy_req = '0;
      repeat (20) @(negedge clk0);
    end
  endtask

  initial begin
    seed          = SEED_INIT;
    errors        = 0;
    reads_checked = 0;
    rst_n         = 1'b0;
    phy_req       = '0;
    shift_mode    = 1'b0;
    skew          = '0;
    run_scenario(1'b0, -1);
    run_scenario(1'b1, -1);
    run_scenario(1'b0, int'($unsigned($random(seed)) % DATA_WIDTH));
    $display("reads checked %0d, scoreboard errors %0d, assertion failures %0d",
             reads_checked, errors, dut.u_sva.fail_cnt);
    if (errors == 0 && dut.u_sva.fail_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * 2 * CLK_HALF);
    $display("watchdog expired before all scenarios finished");
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- build.f
src/qdrc_pkg.sv
src/qdrc_phy_sm.sv
src/qdrc_phy_bit_align.sv
src/qdrc_phy_burst_align.sv
src/qdrc_phy.sv
verification/qdrc_sram_model.sv
verification/qdrc_phy_sva.sv
verification/qdrc_phy_tb.sv

//--- Bender.yml
package:
  name: qdrc_phy

sources:
  - src/qdrc_pkg.sv
  - src/qdrc_phy_sm.sv
  - src/qdrc_phy_bit_align.sv
  - src/qdrc_phy_burst_align.sv
  - src/qdrc_phy.sv
  - target: test
    files:
      - verification/qdrc_sram_model.sv
      - verification/qdrc_phy_sva.sv
      - verification/qdrc_phy_tb.sv
